//--- compile.f
hdl/cpuPkg.sv
hdl/regFile.sv
hdl/insnDecode.sv
hdl/execUnit.sv
hdl/wordMemory.sv
hdl/cpuCore.sv
hdl/cpuSystem.sv
test/storeChecker.sv
test/cpuSystemTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the cpuSystem testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f compile.f --top-module cpuSystemTb -o cpuSystemSim
./obj_dir/cpuSystemSim | tee sim.log

if grep -q "TB PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- test/cpuSystemTb.sv
module cpuSystemTb;
    import cpuPkg::*;

    // Instruction forms as {kind, storing, derefRhs}
    localparam logic [2:0] formWrite  = 3'b000;
    localparam logic [2:0] formLoad   = 3'b001;
    localparam logic [2:0] formStore  = 3'b010;   // [z] = result
    localparam logic [2:0] formStoreZ = 3'b011;   // [result] = z
    localparam logic [2:0] formSwap   = 3'b110;
    localparam int         doneTimeout = 5000;

    logic       clk, reset_n, halt, progWe;
    logic       halted, storeStrobe, running, done;
    word_t      progAddr, progData, storeAddr, storeData;
    int         failCount;
    insn_t      progTable [$];
    word_t      randState, xReg, yReg;
    logic [3:0] swapOps [9];

    cpuSystem i_cpuSystem (.*);
    storeChecker u_storeChecker (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic word_t lcgStep(input word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    task automatic drawImm(output logic [11:0] imm);
        randState = lcgStep(randState);
        imm = randState[31:20];                   // High bits of an LCG are the best mixed
    endtask

    task automatic putInsn(input logic [2:0] form, input logic [3:0] z, input logic [3:0] x,
                           input logic [3:0] y, input logic [3:0] op, input logic [11:0] imm);
        progTable.push_back({1'b0, form, z, x, y, op, imm});
    endtask

    task automatic expectStore(input string name, input word_t addr, input word_t data);
        u_storeChecker.addExpected(name, addr, data);
    endtask

    // Reference ALU, a op b and then plus c
    function automatic word_t aluModel(input logic [3:0] op, input word_t a, input word_t b,
                                       input word_t c);
        word_t r;
        case (op)
            opOr:     r = a | b;
            opAnd:    r = a & b;
            opAdd:    r = a + b;
            opMul:    r = a * b;
            opShl:    r = a << b;
            opCmpLt:  r = ($signed(a) < $signed(b)) ? 32'hffff_ffff : 32'd0;
            opCmpEq:  r = (a == b) ? 32'hffff_ffff : 32'd0;
            opCmpGt:  r = ($signed(a) > $signed(b)) ? 32'hffff_ffff : 32'd0;
            opAndNot: r = a & ~b;
            opXor:    r = a ^ b;
            opSub:    r = a - b;
            opXnor:   r = ~(a ^ b);
            opShr:    r = a >> b;
            opCmpNe:  r = (a != b) ? 32'hffff_ffff : 32'd0;
            default:  return 32'd0;               // Reserved, addend dropped as well
        endcase
        return r + c;
    endfunction

    task automatic buildProgram();
        logic [11:0] imm;
        word_t       memVal;
        word_t       pAddr;
        drawImm(imm);
        xReg = sext12(imm);
        putInsn(formWrite, 4'd1, 4'd0, 4'd0, opOr, imm);
        drawImm(imm);
        yReg = {27'd0, imm[4:0]};                 // Small, so shifts keep some bits
        putInsn(formWrite, 4'd2, 4'd0, 4'd0, opOr, {7'd0, imm[4:0]});
        for (int op = 0; op < 16; op++) begin
            drawImm(imm);
            putInsn(formStore, 4'd0, 4'd1, 4'd2, op[3:0], imm);
            expectStore($sformatf("alu_op%0d", op), 32'd0,
                        aluModel(op[3:0], xReg, yReg, sext12(imm)));
        end
        foreach (swapOps[i]) begin
            drawImm(imm);
            if (swapOps[i] == opShl || swapOps[i] == opShr) begin
                imm = {7'd0, imm[4:0]};
            end
            putInsn(formSwap, 4'd0, 4'd1, 4'd2, swapOps[i], imm);
            expectStore($sformatf("swap_op%0d", swapOps[i]), 32'd0,
                        aluModel(swapOps[i], xReg, sext12(imm), yReg));
        end
        drawImm(imm);
        memVal = sext12(imm);
        putInsn(formWrite, 4'd4, 4'd0, 4'd0, opOr, imm);
        putInsn(formWrite, 4'd6, 4'd0, 4'd0, opOr, 12'd30);
        putInsn(formStoreZ, 4'd4, 4'd0, 4'd0, opOr, 12'd20);
        expectStore("mem_indirect", 32'd20, memVal);
        putInsn(formLoad, 4'd5, 4'd0, 4'd0, opOr, 12'd20);     // r5 back from [20]
        putInsn(formStoreZ, 4'd5, 4'd0, 4'd0, opAdd, 12'd21);
        expectStore("mem_load", 32'd21, memVal);
        putInsn(formStore, 4'd6, 4'd5, 4'd0, opAdd, 12'd1);
        expectStore("mem_direct", 32'd30, memVal + 32'd1);
        putInsn(formStoreZ, 4'd0, 4'd0, 4'd0, opOr, 12'd5);
        expectStore("store_r0", 32'd5, 32'd0);
        putInsn(formWrite, 4'd0, 4'd0, 4'd0, opOr, 12'h7ff);   // Has no effect
        putInsn(formStoreZ, 4'd0, 4'd0, 4'd0, opOr, 12'd7);
        expectStore("write_r0", 32'd7, 32'd0);
        pAddr = progTable.size();
        putInsn(formStoreZ, regP, 4'd0, 4'd0, opOr, 12'd6);
        expectStore("store_p", 32'd6, pAddr + 32'd1);
        putInsn(formWrite, regP, regP, 4'd0, opAdd, 12'd1);    // P + 1 skips one word
        putInsn(formStoreZ, regP, 4'd0, 4'd0, opOr, 12'd8);
        putInsn(formStoreZ, 4'd4, 4'd0, 4'd0, opOr, 12'd9);
        expectStore("jump_target", 32'd9, memVal);
        progTable.push_back(insnIllegal);
    endtask

    initial begin
        int cycles;
        reset_n   = 1'b0;
        halt      = 1'b1;                         // Core stays in fetch while loading
        progWe    = 1'b0;
        progAddr  = '0;
        progData  = '0;
        running   = 1'b0;
        randState = 32'h79d5_dc6d;
        swapOps   = '{opAdd, opSub, opMul, opShl, opShr, opCmpLt, opCmpEq, opCmpGt, opCmpNe};
        buildProgram();
        repeat (16) @(negedge clk);
        reset_n = 1'b1;
        foreach (progTable[i]) begin
            @(negedge clk);
            progWe   = 1'b1;
            progAddr = i;
            progData = progTable[i];
        end
        @(negedge clk);
        progWe  = 1'b0;
        halt    = 1'b0;
        running = 1'b1;
        cycles  = 0;
        while (done !== 1'b1 && cycles < doneTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (done !== 1'b1) begin
            $display("Store checker did not finish within %0d cycles", doneTimeout);
            $display("TB FAILED");
        end else if (failCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- test/storeChecker.sv
module storeChecker (
    input  logic          clk,
    input  logic          running,
    input  logic          storeStrobe,
    input  cpuPkg::word_t storeAddr,
    input  cpuPkg::word_t storeData,
    input  logic          halted,
    output logic          done,
    output int            failCount
);
    import cpuPkg::*;

    localparam int startTimeout = 2000;
    localparam int storeTimeout = 100;            // A few instructions between stores
    localparam int quietCycles  = 60;

    string expName [$];
    word_t expAddr [$];
    word_t expData [$];
    int    passCount;

    task automatic addExpected(input string name, input word_t addr, input word_t data);
        expName.push_back(name);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    // One-cycle strobe sampled mid-cycle
    task automatic waitStore(input int limit, output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < limit) begin
            @(negedge clk);
            cycles++;
            seen = (storeStrobe === 1'b1);
        end
    endtask

    initial begin
        logic seen;
        int   cycles;
        done      = 1'b0;
        failCount = 0;
        passCount = 0;
        cycles    = 0;
        while (running !== 1'b1 && cycles < startTimeout) begin
            @(negedge clk);
            cycles++;
        end
        foreach (expName[i]) begin
            waitStore(storeTimeout, seen);
            if (!seen) begin
                $display("Store for %s never came", expName[i]);
                failCount++;
            end else if (storeAddr === expAddr[i] && storeData === expData[i]) begin
                $display("Pass %s", expName[i]);
                passCount++;
            end else begin
                $display("Fail %s expected addr %h data %h, actual addr %h data %h",
                         expName[i], expAddr[i], expData[i], storeAddr, storeData);
                failCount++;
            end
        end
        // Last program word is the illegal one
        cycles = 0;
        while (halted !== 1'b1 && cycles < storeTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (halted !== 1'b1) begin
            $display("Core did not halt on the illegal instruction");
            failCount++;
        end else begin
            seen = (storeStrobe === 1'b1);        // Memory cycle of the illegal word
            if (!seen) begin
                waitStore(quietCycles, seen);
            end
            if (seen) begin
                $display("Fail illegal_halt expected no store, actual store to %h", storeAddr);
                failCount++;
            end else begin
                $display("Pass illegal_halt");
                passCount++;
            end
        end
        $display("Checks: %0d passed, %0d failed", passCount, failCount);
        done = 1'b1;
    end

endmodule

//--- hdl/cpuSystem.sv
module cpuSystem (
    input  logic          clk,
    input  logic          reset_n,
    input  logic          halt,
    input  logic          progWe,
    input  cpuPkg::word_t progAddr,
    input  cpuPkg::word_t progData,
    output logic          halted,
    output logic          storeStrobe,
    output cpuPkg::word_t storeAddr,
    output cpuPkg::word_t storeData
);
    import cpuPkg::*;

    word_t                   imemAddr;
    word_t                   imemData;
    word_t                   dmemRdata;
    dataBus_t                dataBus;
    logic [imemAddrBits-1:0] imemIdx;

    // Loader owns the instruction memory while halted from outside
    assign imemIdx = halt ? progAddr[imemAddrBits-1:0] : imemAddr[imemAddrBits-1:0];

    cpuCore u_cpuCore (
        .clk       (clk),
        .reset_n   (reset_n),
        .halt      (halt),
        .imemAddr  (imemAddr),
        .imemData  (imemData),
        .dataBus   (dataBus),
        .dmemRdata (dmemRdata),
        .halted    (halted)
    );

    wordMemory #(.addrBits(imemAddrBits)) u_imem (
        .clk   (clk),
        .we    (progWe),
        .addr  (imemIdx),
        .wdata (progData),
        .rdata (imemData)
    );

    wordMemory #(.addrBits(dmemAddrBits)) u_dmem (
        .clk   (clk),
        .we    (dataBus.strobe && dataBus.write),
        .addr  (dataBus.addr[dmemAddrBits-1:0]),
        .wdata (dataBus.wdata),
        .rdata (dmemRdata)
    );

    // Store observation
    assign storeStrobe = dataBus.strobe && dataBus.write;
    assign storeAddr   = dataBus.addr;
    assign storeData   = dataBus.wdata;

endmodule

//--- hdl/cpuCore.sv
module cpuCore (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             halt,
    output cpuPkg::word_t    imemAddr,
    input  cpuPkg::word_t    imemData,
    output cpuPkg::dataBus_t dataBus,
    input  cpuPkg::word_t    dmemRdata,
    output logic             halted
);
    import cpuPkg::*;

    coreState_t state;
    insn_t      insnReg;
    word_t      pc;
    word_t      nextPc;
    word_t      loadData;
    word_t      result;
    word_t      imm;
    word_t      xVal;
    word_t      yVal;
    word_t      zVal;
    word_t      writeValue;
    logic       illegal;
    logic       jump;
    logic       loading;
    logic       memAccess;
    logic       regWrite;

    assign imemAddr = pc;                     // Held through the whole instruction
    assign nextPc   = pc + 32'd1;             // What P reads as

    // Sequencer, six cycles per instruction
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state  <= sFetch;
            pc     <= resetVector;
            halted <= 1'b0;
        end else begin
            case (state)
                sFetch: begin
                    if (!halt && !halted) begin
                        state <= sDecode;
                    end
                end
                sDecode:  state <= sExec;
                sExec: begin
                    state <= sMem;
                    if (illegal) begin
                        halted <= 1'b1;       // Sticky until reset
                    end
                end
                sMem:     state <= sMemWait;
                sMemWait: state <= sCommit;
                sCommit: begin
                    state <= sFetch;
                    if (!halted) begin
                        pc <= jump ? writeValue : nextPc;
                    end
                end
                default:  state <= sFetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == sDecode) begin
            insnReg <= imemData;              // Fetched word is valid here
        end
        if (state == sMemWait) begin
            loadData <= dmemRdata;
        end
    end

    insnDecode u_insnDecode (
        .insn    (insnReg),
        .imm     (imm),
        .illegal (illegal),
        .jump    (jump)
    );

    execUnit u_execUnit (
        .clk    (clk),
        .en     (state == sExec),
        .swap   (insnReg.kind),
        .op     (insnReg.op),
        .xVal   (xVal),
        .yVal   (yVal),
        .imm    (imm),
        .result (result)
    );

    // Memory steering for the four load and store forms
    assign loading    = insnReg.derefRhs && !insnReg.storing;
    assign memAccess  = (state == sMem) && (loading || insnReg.storing) && !halted;
    assign writeValue = loading ? loadData : result;
    assign regWrite   = (state == sCommit) && !insnReg.storing && !halted;

    always_comb begin
        dataBus.strobe = memAccess;
        dataBus.write  = memAccess && insnReg.storing;
        dataBus.addr   = insnReg.derefRhs ? result : zVal;   // [result] or [z]
        dataBus.wdata  = insnReg.derefRhs ? zVal : result;
    end

    regFile u_regFile (
        .clk       (clk),
        .writeEn   (regWrite),
        .xIdx      (insnReg.x),
        .yIdx      (insnReg.y),
        .zIdx      (insnReg.z),
        .writeData (writeValue),
        .nextPc    (nextPc),
        .xVal      (xVal),
        .yVal      (yVal),
        .zVal      (zVal)
    );

endmodule

//--- hdl/wordMemory.sv
module wordMemory #(
    parameter int addrBits = cpuPkg::imemAddrBits
) (
    input  logic                clk,
    input  logic                we,
    input  logic [addrBits-1:0] addr,
    input  cpuPkg::word_t       wdata,
    output cpuPkg::word_t       rdata
);
    import cpuPkg::*;

    word_t mem [2**addrBits];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];                   // Old contents on a write
    end

endmodule

//--- hdl/execUnit.sv
module execUnit (
    input  logic          clk,
    input  logic          en,
    input  logic          swap,
    input  logic [3:0]    op,
    input  cpuPkg::word_t xVal,
    input  cpuPkg::word_t yVal,
    input  cpuPkg::word_t imm,
    output cpuPkg::word_t result
);
    import cpuPkg::*;

    word_t operand;
    word_t addend;
    word_t opVal;
    logic  reserved;

    assign operand = swap ? imm : yVal;
    assign addend  = swap ? yVal : imm;

    always_comb begin
        opVal    = '0;
        reserved = 1'b0;
        case (op)
            opOr:     opVal = xVal | operand;
            opAnd:    opVal = xVal & operand;
            opAdd:    opVal = xVal + operand;
            opMul:    opVal = xVal * operand;            // Low 32 bits
            opShl:    opVal = xVal << operand;
            opCmpLt:  opVal = {32{$signed(xVal) < $signed(operand)}};
            opCmpEq:  opVal = {32{xVal == operand}};
            opCmpGt:  opVal = {32{$signed(xVal) > $signed(operand)}};
            opAndNot: opVal = xVal & ~operand;
            opXor:    opVal = xVal ^ operand;
            opSub:    opVal = xVal - operand;
            opXnor:   opVal = xVal ^ ~operand;
            opShr:    opVal = xVal >> operand;
            opCmpNe:  opVal = {32{xVal != operand}};
            opRes4, opRes15: reserved = 1'b1;            // Whole result is zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (en) begin
            result <= reserved ? '0 : opVal + addend;
        end
    end

endmodule

//--- hdl/insnDecode.sv
module insnDecode (
    input  cpuPkg::insn_t insn,
    output cpuPkg::word_t imm,
    output logic          illegal,
    output logic          jump
);
    import cpuPkg::*;

    logic immSign;

    assign immSign = insn.imm[11];

    // 12-bit immediate to a full word
    assign imm = {{20{immSign}}, insn.imm};

    // All-ones word halts the core
    assign illegal = (insn == insnIllegal);

    // Register write to P redirects the fetch, stores to [P] do not
    assign jump = (insn.z == regP) && !insn.storing;

endmodule

//--- hdl/regFile.sv
module regFile (
    input  logic          clk,
    input  logic          writeEn,
    input  logic [3:0]    xIdx,
    input  logic [3:0]    yIdx,
    input  logic [3:0]    zIdx,
    input  cpuPkg::word_t writeData,
    input  cpuPkg::word_t nextPc,
    output cpuPkg::word_t xVal,
    output cpuPkg::word_t yVal,
    output cpuPkg::word_t zVal
);
    import cpuPkg::*;

    word_t regs [1:14];                      // No storage behind 0 and P

    function automatic word_t readReg(input logic [3:0] idx);
        if (idx == 4'd0)
            return '0;
        else if (idx == regP)
            return nextPc;
        else
            return regs[idx];
    endfunction

    assign xVal = readReg(xIdx);
    assign yVal = readReg(yIdx);
    assign zVal = readReg(zIdx);

    always_ff @(posedge clk) begin
        if (writeEn && zIdx != 4'd0 && zIdx != regP) begin
            regs[zIdx] <= writeData;
        end
    end

endmodule

//--- hdl/cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] word_t;

    // Instruction word, top bit down
    typedef struct packed {
        logic        spare;
        logic        kind;      // 1 = X op imm plus Y
        logic        storing;
        logic        derefRhs;
        logic [3:0]  z;
        logic [3:0]  x;
        logic [3:0]  y;
        logic [3:0]  op;
        logic [11:0] imm;
    } insn_t;

    typedef struct packed {
        logic  strobe;
        logic  write;
        word_t addr;
        word_t wdata;
    } dataBus_t;

    typedef enum logic [2:0] {
        sFetch, sDecode, sExec, sMem, sMemWait, sCommit
    } coreState_t;

    localparam word_t      resetVector = 32'h0000_0000;
    localparam word_t      insnIllegal = 32'hffff_ffff;
    localparam logic [3:0] regP        = 4'd15;         // Reads as program counter

    localparam int imemAddrBits = 8;
    localparam int dmemAddrBits = 6;

    // ALU operation codes
    localparam logic [3:0] opOr     = 4'd0;
    localparam logic [3:0] opAnd    = 4'd1;
    localparam logic [3:0] opAdd    = 4'd2;
    localparam logic [3:0] opMul    = 4'd3;
    localparam logic [3:0] opRes4   = 4'd4;   // Reserved
    localparam logic [3:0] opShl    = 4'd5;
    localparam logic [3:0] opCmpLt  = 4'd6;
    localparam logic [3:0] opCmpEq  = 4'd7;
    localparam logic [3:0] opCmpGt  = 4'd8;
    localparam logic [3:0] opAndNot = 4'd9;
    localparam logic [3:0] opXor    = 4'd10;
    localparam logic [3:0] opSub    = 4'd11;
    localparam logic [3:0] opXnor   = 4'd12;
    localparam logic [3:0] opShr    = 4'd13;  // Logical
    localparam logic [3:0] opCmpNe  = 4'd14;
    localparam logic [3:0] opRes15  = 4'd15;  // Reserved

endpackage
